// ==== verilog/nocRouter_cfg.svh ====
`ifndef NOC_ROUTER_CFG_SVH
`define NOC_ROUTER_CFG_SVH

// ============================================================
// Router output port configuration
// ============================================================

// Input ports feeding this output. The arbiter is written for five.
`define NOC_PORTS 5

// Entries per input queue, kept a power of two.
`define NOC_FIFO_DEPTH 4

`define NOC_KIND_W 3   // Flit kind field.
`define NOC_LEN_W  12  // Length and timeout budget field.
`define NOC_DATA_W 16  // Payload.

`define NOC_STATE_W 6  // One-hot arbiter state.

`endif

// ==== verilog/nocPkg.sv ====
`default_nettype none
`include "nocRouter_cfg.svh"

package nocPkg;

  // ============================================================
  // Flit format
  // ============================================================

  typedef enum logic [`NOC_KIND_W-1:0]
  {
    FlitIdle = 3'd0,
    FlitHead = 3'd1,  // Carries the timeout budget in length.
    FlitBody = 3'd2,
    FlitTail = 3'd4
  } flitKind_e;

  typedef struct packed
  {
    logic [`NOC_KIND_W-1:0] kind;
    logic [`NOC_LEN_W-1:0]  length;
    logic [`NOC_DATA_W-1:0] data;
  } flit_t;

  // ============================================================
  // Arbitration
  // ============================================================

  // Grant bits sit above the idle bit in port index order.
  typedef enum logic [`NOC_STATE_W-1:0]
  {
    ArbIdle = 6'b000001,
    GrantL  = 6'b000010,
    GrantN  = 6'b000100,
    GrantE  = 6'b001000,
    GrantW  = 6'b010000,
    GrantS  = 6'b100000
  } arbState_e;

  typedef enum logic [2:0]
  {
    PortL = 3'd0,
    PortN = 3'd1,
    PortE = 3'd2,
    PortW = 3'd3,
    PortS = 3'd4
  } portIdx_e;

endpackage

`default_nettype wire

// ==== verilog/flitFifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "nocRouter_cfg.svh"

module flitFifo
(
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  nocPkg::flit_t pushFlit,
  input  logic          pop,
  output nocPkg::flit_t headFlit,
  output logic          empty,
  output logic          full
);

  localparam int Depth = `NOC_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);

  nocPkg::flit_t   mem [Depth];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [PtrW:0]   count;
  logic            doPush;
  logic            doPop;

  assign doPush = push && !full;   // Push into a full queue is dropped.
  assign doPop  = pop && !empty;

  assign empty    = (count == '0);
  assign full     = (count == (PtrW+1)'(Depth));
  assign headFlit = mem[rdPtr];

  // ============================================================
  // Storage
  // ============================================================

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      mem[wrPtr] <= pushFlit;
    end
  end

  // ============================================================
  // Pointers and occupancy
  // ============================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;  // Wraps on its own, depth is a power of two.
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/grantTimer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "nocRouter_cfg.svh"

module grantTimer
(
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t headFlit,
  input  logic          run,
  output logic          timesUp
);

  logic [`NOC_LEN_W-1:0] budget;
  logic [`NOC_LEN_W-1:0] cycles;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      cycles <= '0;
    end
    else
    begin
      // Latest header at the queue head sets the budget.
      if (headFlit.kind == nocPkg::FlitHead)
        budget <= headFlit.length;

      if (run)
        cycles <= cycles + 1'b1;
      else
        cycles <= '0;  // Any cycle without a pop restarts the count.
    end
  end

  assign timesUp = (cycles == budget);

endmodule

`default_nettype wire

// ==== verilog/switchArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "nocRouter_cfg.svh"

module switchArbiter
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic          [`NOC_PORTS-1:0]  req,
  input  nocPkg::flit_t [`NOC_PORTS-1:0]  headFlits,
  output logic          [`NOC_PORTS-1:0]  pop,
  output nocPkg::arbState_e               state
);

  nocPkg::arbState_e     nextState;
  nocPkg::portIdx_e      grantIdx;
  logic [`NOC_PORTS-1:0] timesUp;

  // Grant state for a port index.
  function automatic nocPkg::arbState_e grantOf(input int idx);
    grantOf = nocPkg::arbState_e'(6'b000010 << idx);
  endfunction

  // First requesting port after the given one, going round the ring.
  // The given port itself comes last.
  function automatic nocPkg::arbState_e pickNext
  (
    input logic [`NOC_PORTS-1:0] r,
    input nocPkg::portIdx_e      after
  );
    nocPkg::arbState_e pick;
    int                idx;
    pick = nocPkg::ArbIdle;
    for (int k = `NOC_PORTS; k >= 1; k--)
    begin
      idx = (int'(after) + k) % `NOC_PORTS;
      if (r[idx])
        pick = grantOf(idx);  // Nearest offset is written last and wins.
    end
    return pick;
  endfunction

  // ============================================================
  // Grant timers
  // ============================================================

  for (genvar g = 0; g < `NOC_PORTS; g++)
  begin : gTimer
    grantTimer u_grantTimer
    (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlits[g]),
      .run      (pop[g]),
      .timesUp  (timesUp[g])
    );
  end

  // ============================================================
  // State register and next state
  // ============================================================

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::ArbIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      nocPkg::GrantN: grantIdx = nocPkg::PortN;
      nocPkg::GrantE: grantIdx = nocPkg::PortE;
      nocPkg::GrantW: grantIdx = nocPkg::PortW;
      nocPkg::GrantS: grantIdx = nocPkg::PortS;
      default:        grantIdx = nocPkg::PortL;
    endcase
  end

  always_comb
  begin
    pop       = '0;
    nextState = nocPkg::ArbIdle;
    case (state)
      nocPkg::ArbIdle:
      begin
        nextState = pickNext(req, nocPkg::PortS);  // Gives L, N, E, W, S.
      end
      nocPkg::GrantL, nocPkg::GrantN, nocPkg::GrantE,
      nocPkg::GrantW, nocPkg::GrantS:
      begin
        if (req[grantIdx] && !timesUp[grantIdx])
        begin
          pop[grantIdx] = 1'b1;
          nextState     = state;
        end
        else
        begin
          nextState = pickNext(req, grantIdx);
        end
      end
      default:
      begin
        nextState = nocPkg::ArbIdle;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/outputLink.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "nocRouter_cfg.svh"

module outputLink
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic          [`NOC_PORTS-1:0]  pop,
  input  nocPkg::flit_t [`NOC_PORTS-1:0]  headFlits,
  output nocPkg::flit_t                   outFlit,
  output nocPkg::portIdx_e                outPort,
  output logic                            outValid
);

  nocPkg::portIdx_e selPort;
  nocPkg::flit_t    selFlit;

  // One-hot pop to port index.
  always_comb
  begin
    selPort = nocPkg::PortL;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      if (pop[i])
        selPort = nocPkg::portIdx_e'(i);
    end
  end

  assign selFlit = headFlits[selPort];

  // ============================================================
  // Link register
  // ============================================================

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    outPort <= selPort;  // Source port tag.
  end

endmodule

`default_nettype wire

// ==== verilog/nocOutputPort.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "nocRouter_cfg.svh"

module nocOutputPort
(
  input  logic                            clk,
  input  logic                            rst,
  input  nocPkg::flit_t [`NOC_PORTS-1:0]  inFlit,
  input  logic          [`NOC_PORTS-1:0]  inValid,
  output logic          [`NOC_PORTS-1:0]  inFull,
  output nocPkg::flit_t                   outFlit,
  output nocPkg::portIdx_e                outPort,
  output logic                            outValid
);

  logic          [`NOC_PORTS-1:0] fifoEmpty;
  logic          [`NOC_PORTS-1:0] req;
  logic          [`NOC_PORTS-1:0] pop;
  nocPkg::flit_t [`NOC_PORTS-1:0] headFlits;

  assign req = ~fifoEmpty;

  // ============================================================
  // Input queues
  // ============================================================

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : gQueue
    flitFifo u_flitFifo
    (
      .clk      (clk),
      .rst      (rst),
      .push     (inValid[p]),
      .pushFlit (inFlit[p]),
      .pop      (pop[p]),
      .headFlit (headFlits[p]),
      .empty    (fifoEmpty[p]),
      .full     (inFull[p])
    );
  end

  // ============================================================
  // Arbitration and link
  // ============================================================

  switchArbiter u_switchArbiter
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .headFlits (headFlits),
    .pop       (pop),
    .state     ()
  );

  outputLink u_outputLink
  (
    .clk       (clk),
    .rst       (rst),
    .pop       (pop),
    .headFlits (headFlits),
    .outFlit   (outFlit),
    .outPort   (outPort),
    .outValid  (outValid)
  );

endmodule

`default_nettype wire

// ==== verification/tbNocOutputPort.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "nocRouter_cfg.svh"

module tbNocOutputPort;

  localparam int Ports     = `NOC_PORTS;
  localparam int MaxCycles = 3000;  // Ample bound over the few hundred cycles of all tests.

  logic                            clk;
  logic                            rst;
  nocPkg::flit_t [Ports-1:0]       inFlit;
  logic          [Ports-1:0]       inValid;
  logic          [Ports-1:0]       inFull;
  nocPkg::flit_t                   outFlit;
  nocPkg::portIdx_e                outPort;
  logic                            outValid;

  nocPkg::flit_t stage [Ports];     // Next flit per port for pushFlits.
  nocPkg::flit_t modelQ [Ports][$]; // Expected flits per source port.
  int            outLog[$];         // Source ports in output order.
  string         testName;
  logic [31:0]   rngState;
  int            skipped;
  logic          sawFull;

  nocOutputPort u_nocOutputPort
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inFull   (inFull),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run went past %0d cycles without draining", MaxCycles);
    $display("Finished with errors");
    $fatal(1);
  end

  // ============================================================
  // Helpers
  // ============================================================

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic nocPkg::flit_t makeFlit(nocPkg::flitKind_e kind, int len, int data);
    nocPkg::flit_t f;
    f.kind   = kind;
    f.length = `NOC_LEN_W'(len);
    f.data   = `NOC_DATA_W'(data);
    return f;
  endfunction

  // Head flits always get a non-zero budget.
  function automatic nocPkg::flit_t randomFlit();
    logic [31:0] r;
    r = nextRand();
    case (r % 3)
      0:       return makeFlit(nocPkg::FlitHead, 1 + int'((r >> 8) % 7), int'(r[31:16]));
      1:       return makeFlit(nocPkg::FlitBody, 0, int'(r[31:16]));
      default: return makeFlit(nocPkg::FlitTail, 0, int'(r[31:16]));
    endcase
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < Ports; p++)
      n += modelQ[p].size();
    return n;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // Push once on the masked ports and idle a cycle so inFull is current.
  task automatic pushFlits(input logic [Ports-1:0] mask);
    @(posedge clk);
    for (int p = 0; p < Ports; p++)
    begin
      if (mask[p] && inFull[p])
        skipped++;
      else if (mask[p])
      begin
        inValid[p] <= 1'b1;
        inFlit[p]  <= stage[p];
        modelQ[p].push_back(stage[p]);
      end
    end
    @(posedge clk);
    inValid <= '0;
  endtask

  task automatic waitDrain();
    while (pending() > 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  // ============================================================
  // Monitor
  // ============================================================

  always @(negedge clk)
  begin
    nocPkg::flit_t exp;
    int            port;
    if (!rst)
    begin
      if (|inFull)
        sawFull = 1'b1;
      if (outValid)
      begin
        port = int'(outPort);
        if (port >= Ports)
        begin
          $display("Output tagged with unknown port %0d in test %s", port, testName);
          $display("Finished with errors");
          $fatal(1);
        end
        else if (modelQ[port].size() == 0)
        begin
          $display("Unexpected flit from port %0d in test %s", port, testName);
          $display("Finished with errors");
          $fatal(1);
        end
        else
        begin
          exp = modelQ[port].pop_front();
          check(testName, 64'(exp), 64'(outFlit));
          outLog.push_back(port);
        end
      end
    end
  end

  // ============================================================
  // Tests
  // ============================================================

  task automatic testSingle();
    testName = "single";
    outLog.delete();
    check("reset", 64'(0), 64'({outValid, inFull}));
    for (int i = 0; i < 4; i++)
    begin
      if (i == 0)
        stage[nocPkg::PortW] = makeFlit(nocPkg::FlitHead, 4, 'h1000);
      else
        stage[nocPkg::PortW] = makeFlit(nocPkg::FlitBody, 0, 'h1000 + i);
      pushFlits(5'b01000);
    end
    waitDrain();
    check(testName, 64'(4), 64'(outLog.size()));
  endtask

  task automatic testIdleOrder();
    testName = "idleOrder";
    outLog.delete();
    for (int p = 0; p < Ports; p++)
      stage[p] = makeFlit(nocPkg::FlitHead, 2, 'h2000 + p);
    pushFlits('1);
    waitDrain();
    for (int i = 0; i < Ports; i++)
      check(testName, 64'(i), 64'(outLog[i]));
  endtask

  task automatic testRotation();
    int others[$];
    testName = "rotation";
    outLog.delete();
    stage[nocPkg::PortE] = makeFlit(nocPkg::FlitHead, 8, 'h3000);
    pushFlits(5'b00100);
    stage[nocPkg::PortE] = makeFlit(nocPkg::FlitBody, 0, 'h3001);
    stage[nocPkg::PortL] = makeFlit(nocPkg::FlitHead, 2, 'h3100);
    stage[nocPkg::PortS] = makeFlit(nocPkg::FlitHead, 2, 'h3400);
    pushFlits(5'b10101);
    stage[nocPkg::PortE] = makeFlit(nocPkg::FlitTail, 0, 'h3002);
    pushFlits(5'b00100);
    waitDrain();
    foreach (outLog[i])
      if (outLog[i] != int'(nocPkg::PortE))
        others.push_back(outLog[i]);
    check(testName, 64'(2), 64'(others.size()));
    check(testName, 64'(nocPkg::PortS), 64'(others[0]));
    check(testName, 64'(nocPkg::PortL), 64'(others[1]));
  endtask

  // N bursts four flits on back-to-back cycles with a budget of 3 while W waits.
  task automatic testTimeout();
    nocPkg::flit_t f;
    int            run;
    logic          sawW;
    testName = "timeout";
    outLog.delete();
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
      if (i == 0)
        f = makeFlit(nocPkg::FlitHead, 3, 'h4000);
      else
        f = makeFlit(nocPkg::FlitBody, 0, 'h4000 + i);
      inValid <= '0;
      inValid[nocPkg::PortN] <= 1'b1;
      inFlit[nocPkg::PortN]  <= f;
      modelQ[nocPkg::PortN].push_back(f);
      if (i == 0)
      begin
        f = makeFlit(nocPkg::FlitHead, 2, 'h4300);
        inValid[nocPkg::PortW] <= 1'b1;
        inFlit[nocPkg::PortW]  <= f;
        modelQ[nocPkg::PortW].push_back(f);
      end
    end
    @(posedge clk);
    inValid <= '0;
    waitDrain();
    run  = 0;
    sawW = 1'b0;
    foreach (outLog[i])
    begin
      if (outLog[i] == int'(nocPkg::PortW))
        sawW = 1'b1;
      else if (!sawW)
        run++;
    end
    check(testName, 64'(1), 64'(sawW));
    check(testName, 64'(1), 64'(run <= 3));
  endtask

  task automatic testFullRandom();
    testName = "fullRandom";
    outLog.delete();
    sawFull = 1'b0;
    skipped = 0;
    repeat (8)
    begin
      for (int p = 0; p < Ports; p++)
        stage[p] = randomFlit();
      pushFlits('1);
    end
    check(testName, 64'(1), 64'(sawFull));
    check(testName, 64'(1), 64'(skipped > 0));
    repeat (40)
    begin
      for (int p = 0; p < Ports; p++)
        stage[p] = randomFlit();
      pushFlits(Ports'(nextRand()));
    end
    waitDrain();
  endtask

  initial
  begin
    rst      = 1'b1;
    inValid  = '0;
    inFlit   = '0;
    rngState = 32'hbecb;
    skipped  = 0;
    sawFull  = 1'b0;
    testName = "reset";
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    testSingle();
    testIdleOrder();
    testRotation();
    testTimeout();
    testFullRandom();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/nocPkg.sv
verilog/flitFifo.sv
verilog/grantTimer.sv
verilog/switchArbiter.sv
verilog/outputLink.sv
verilog/nocOutputPort.sv
verification/tbNocOutputPort.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --timing
TOP   = tbNocOutputPort
FLIST = flist.f
LOG   = sim.log
OBJ   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ)/V$(TOP): $(FLIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
